/* hw/llr_fifo.sv */
`timescale 1ns/1ps

`include "rx_params.svh"

module llr_fifo (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      clear_i,

    input  rx_types_pkg::llr_pair_t   wr_data_i,
    input  logic                      wr_last_i,
    input  logic                      wr_valid_i,

    input  logic                      pop_i,
    output rx_types_pkg::llr_pair_t   head_data_o,
    output logic                      head_last_o,
    output logic                      head_valid_o,

    output rx_types_pkg::fifo_level_t level_o,
    output logic                      overflow_o
);

    import rx_types_pkg::*;

    localparam int DEPTH = `RX_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    llr_pair_t          mem_data [DEPTH];
    logic               mem_last [DEPTH];
    logic [PTR_W - 1 : 0] wr_ptr;
    logic [PTR_W - 1 : 0] rd_ptr;
    fifo_level_t        count;
    logic               ovf;
    logic               full;
    logic               empty;
    logic               wr_en;
    logic               rd_en;

    function automatic logic [PTR_W - 1 : 0] ptr_inc(input logic [PTR_W - 1 : 0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == fifo_level_t'(DEPTH));
    assign empty = (count == '0);

    // full drops the write even if a pop lands in the same cycle
    assign wr_en = wr_valid_i && !full;
    assign rd_en = pop_i && !empty;

    // ---------------------------------------------------------------------------
    // storage
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= wr_data_i;
            mem_last[wr_ptr] <= wr_last_i;
        end
    end

    // ---------------------------------------------------------------------------
    // pointers, fill count, sticky overflow
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf    <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr_valid_i && full) begin
                ovf <= 1'b1;
            end
        end
    end

    assign head_data_o  = mem_data[rd_ptr];
    assign head_last_o  = mem_last[rd_ptr];
    assign head_valid_o = !empty;
    assign level_o      = count;
    assign overflow_o   = ovf;

endmodule

/* hw/llr_regmap.sv */
`timescale 1ns/1ps

`include "rx_params.svh"

module llr_regmap (
    input  logic                      clk_i,
    input  logic                      reset_ni,

    input  rx_regmap_pkg::reg_addr_e  rd_addr_i,
    input  logic                      rd_strobe_i,

    input  rx_types_pkg::llr_pair_t   head_data_i,
    input  logic                      head_last_i,
    input  logic                      head_valid_i,
    input  rx_types_pkg::fifo_level_t level_i,
    input  logic                      overflow_i,

    output logic                      pop_o,
    output rx_regmap_pkg::reg_word_t  rd_data_o,
    output logic                      rd_valid_o
);

    import rx_regmap_pkg::*;

    reg_word_t status_word;
    reg_word_t data_word;
    reg_word_t rd_word;

    always_comb begin
        status_word                   = '0;
        status_word[STATUS_OVF_BIT]   = overflow_i;
        status_word[STATUS_EMPTY_BIT] = !head_valid_i;
    end

    // empty fifo reads back as all zero
    always_comb begin
        data_word = '0;
        if (head_valid_i) begin
            data_word[15 : 0]        = head_data_i;
            data_word[DATA_LAST_BIT]  = head_last_i;
            data_word[DATA_VALID_BIT] = 1'b1;
        end
    end

    always_comb begin
        case (rd_addr_i)
            REG_ID:       rd_word = `RX_CORE_ID;
            REG_LEVEL:    rd_word = reg_word_t'(level_i);
            REG_STATUS:   rd_word = status_word;
            REG_LLR_DATA: rd_word = data_word;
            default:      rd_word = '0;
        endcase
    end

    // fifo ignores the pop when empty
    assign pop_o = rd_strobe_i && (rd_addr_i == REG_LLR_DATA);

    // word is taken before the pop lands
    always_ff @(posedge clk_i) begin
        if (rd_strobe_i) begin
            rd_data_o <= rd_word;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_strobe_i;
        end
    end

endmodule

/* hw/pbch_demap.sv */
`timescale 1ns/1ps

`include "rx_params.svh"

module pbch_demap (
    input  logic                    clk_i,
    input  logic                    reset_ni,
    input  logic                    clear_i,

    input  rx_types_pkg::iq_t       sym_data_i,
    input  rx_types_pkg::sym_type_e sym_type_i,
    input  logic                    sym_last_i,
    input  logic                    sym_valid_i,

    output rx_types_pkg::llr_pair_t llr_data_o,
    output logic                    llr_last_o,
    output logic                    llr_valid_o
);

    import rx_types_pkg::*;

    // symmetric llr range, -128 folds onto -127
    localparam int LLR_MAX = 2 ** (`RX_LLR_DW - 1) - 1;

    logic pbch_hit;

    function automatic llr_t sat_llr(input logic signed [`RX_IQ_DW - 1 : 0] comp);
        if (comp > LLR_MAX) begin
            return llr_t'(LLR_MAX);
        end else if (comp < -LLR_MAX) begin
            return llr_t'(-LLR_MAX);
        end
        return llr_t'(comp);
    endfunction

    // only PBCH data goes on, DMRS and the rest are dropped here
    assign pbch_hit = sym_valid_i && (sym_type_i == SYM_PBCH);

    always_ff @(posedge clk_i) begin
        if (!reset_ni || clear_i) begin
            llr_valid_o <= 1'b0;
        end else begin
            llr_valid_o <= pbch_hit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pbch_hit) begin
            llr_data_o.i <= sat_llr(sym_data_i.i);
            llr_data_o.q <= sat_llr(sym_data_i.q);
            llr_last_o   <= sym_last_i;
        end
    end

endmodule

/* hw/pbch_llr_capture.sv */
`timescale 1ns/1ps

module pbch_llr_capture (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  logic                     clear_i,

    input  rx_types_pkg::iq_t        sym_data_i,
    input  rx_types_pkg::sym_type_e  sym_type_i,
    input  logic                     sym_last_i,
    input  logic                     sym_valid_i,

    input  rx_regmap_pkg::reg_addr_e rd_addr_i,
    input  logic                     rd_strobe_i,
    output rx_regmap_pkg::reg_word_t rd_data_o,
    output logic                     rd_valid_o
);

    import rx_types_pkg::*;

    // demapper to fifo
    llr_pair_t   llr_data;
    logic        llr_last;
    logic        llr_valid;

    // fifo to register map
    llr_pair_t   head_data;
    logic        head_last;
    logic        head_valid;
    fifo_level_t level;
    logic        overflow;
    logic        pop;

    pbch_demap pbch_demap_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .clear_i     (clear_i),
        .sym_data_i  (sym_data_i),
        .sym_type_i  (sym_type_i),
        .sym_last_i  (sym_last_i),
        .sym_valid_i (sym_valid_i),
        .llr_data_o  (llr_data),
        .llr_last_o  (llr_last),
        .llr_valid_o (llr_valid)
    );

    llr_fifo llr_fifo_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .clear_i      (clear_i),
        .wr_data_i    (llr_data),
        .wr_last_i    (llr_last),
        .wr_valid_i   (llr_valid),
        .pop_i        (pop),
        .head_data_o  (head_data),
        .head_last_o  (head_last),
        .head_valid_o (head_valid),
        .level_o      (level),
        .overflow_o   (overflow)
    );

    llr_regmap llr_regmap_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .rd_addr_i    (rd_addr_i),
        .rd_strobe_i  (rd_strobe_i),
        .head_data_i  (head_data),
        .head_last_i  (head_last),
        .head_valid_i (head_valid),
        .level_i      (level),
        .overflow_i   (overflow),
        .pop_o        (pop),
        .rd_data_o    (rd_data_o),
        .rd_valid_o   (rd_valid_o)
    );

endmodule

/* hw/rx_params.svh */
`ifndef RX_PARAMS_SVH
`define RX_PARAMS_SVH

// ---------------------------------------------------------------------------
// datapath widths
// ---------------------------------------------------------------------------

// one I or Q component of an equalized symbol
`define RX_IQ_DW 8

// one soft bit
`define RX_LLR_DW 8

// ---------------------------------------------------------------------------
// capture buffer and identification
// ---------------------------------------------------------------------------

`define RX_FIFO_DEPTH 16

`define RX_CORE_ID 32'h5242_4801

`endif

/* hw/rx_regmap_pkg.sv */
package rx_regmap_pkg;

    // word addresses seen by the host
    typedef enum logic [1 : 0] {
        REG_ID       = 2'd0,
        REG_LEVEL    = 2'd1,
        REG_STATUS   = 2'd2,
        REG_LLR_DATA = 2'd3
    } reg_addr_e;

    typedef logic [31 : 0] reg_word_t;

    // status word layout
    localparam int STATUS_OVF_BIT   = 0;
    localparam int STATUS_EMPTY_BIT = 1;

    // data word layout, pair itself sits in 15:0
    localparam int DATA_VALID_BIT = 31;
    localparam int DATA_LAST_BIT  = 16;

endpackage

/* hw/rx_types_pkg.sv */
`include "rx_params.svh"

package rx_types_pkg;

    // equalized qpsk symbol, I in the upper half
    typedef struct packed {
        logic signed [`RX_IQ_DW - 1 : 0] i;
        logic signed [`RX_IQ_DW - 1 : 0] q;
    } iq_t;

    // resource type tag, PBCH matches the reference encoding
    typedef enum logic [1 : 0] {
        SYM_OTHER = 2'd0,
        SYM_PBCH  = 2'd1,
        SYM_DMRS  = 2'd2
    } sym_type_e;

    typedef logic signed [`RX_LLR_DW - 1 : 0] llr_t;

    typedef struct packed {
        llr_t i;
        llr_t q;
    } llr_pair_t;

    // 0 .. depth inclusive
    typedef logic [$clog2(`RX_FIFO_DEPTH + 1) - 1 : 0] fifo_level_t;

endpackage

/* pbch_llr_capture.f */
+incdir+hw
hw/rx_types_pkg.sv
hw/rx_regmap_pkg.sv
hw/pbch_demap.sv
hw/llr_fifo.sv
hw/llr_regmap.sv
hw/pbch_llr_capture.sv
verification/tb_pbch_llr_capture.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PBCH LLR capture testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f pbch_llr_capture.f \
    --top-module tb_pbch_llr_capture -o sim_bin
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_bin > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "simulation log holds no result line"
    exit 1
fi
exit 0

/* verification/tb_pbch_llr_capture.sv */
`timescale 1ns/1ps

`include "rx_params.svh"

module tb_pbch_llr_capture;

    import rx_types_pkg::*;
    import rx_regmap_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    // reset and the six tests in run order
    localparam int BUDGET_CYCLES = 10 + 20 + 60 + 30 + 70 + 70 + 70;
    localparam int WATCHDOG_NS   = BUDGET_CYCLES * CLK_PERIOD_NS * 2;

    logic        clk_i = 1'b0;
    logic        reset_ni;
    logic        clear_i;
    iq_t         sym_data_i;
    sym_type_e   sym_type_i;
    logic        sym_last_i;
    logic        sym_valid_i;
    reg_addr_e   rd_addr_i;
    logic        rd_strobe_i;
    reg_word_t   rd_data_o;
    logic        rd_valid_o;

    int          check_count;
    int          error_count;
    int          test_count;
    string       test_name;
    logic [31:0] lcg_state;

    always #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;

    pbch_llr_capture dut_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .clear_i     (clear_i),
        .sym_data_i  (sym_data_i),
        .sym_type_i  (sym_type_i),
        .sym_last_i  (sym_last_i),
        .sym_valid_i (sym_valid_i),
        .rd_addr_i   (rd_addr_i),
        .rd_strobe_i (rd_strobe_i),
        .rd_data_o   (rd_data_o),
        .rd_valid_o  (rd_valid_o)
    );

    // ------------------------------------------------------------------------
    // reference model and stimulus helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // -128 has no positive twin and folds onto -127
    function automatic llr_t llr_from_component(input logic signed [`RX_IQ_DW - 1 : 0] c);
        if (c == 8'sh80) begin
            return 8'sh81;
        end
        return llr_t'(c);
    endfunction

    function automatic llr_pair_t pair_from_symbol(input iq_t s);
        llr_pair_t p;
        p.i = llr_from_component(s.i);
        p.q = llr_from_component(s.q);
        return p;
    endfunction

    function automatic reg_word_t data_word_of(input llr_pair_t p, input logic last);
        reg_word_t w;
        w                 = '0;
        w[15 : 0]         = p;
        w[DATA_LAST_BIT]  = last;
        w[DATA_VALID_BIT] = 1'b1;
        return w;
    endfunction

    function automatic reg_word_t status_word_of(input logic ovf, input logic empty);
        reg_word_t w;
        w                   = '0;
        w[STATUS_OVF_BIT]   = ovf;
        w[STATUS_EMPTY_BIT] = empty;
        return w;
    endfunction

    task automatic check_pair(input llr_pair_t exp, input llr_pair_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s: expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_word(input reg_word_t exp, input reg_word_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s: expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_level(input fifo_level_t exp, input fifo_level_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s: expected %0d, actual %0d", test_name, exp, act);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    task automatic send_symbol(input iq_t data, input sym_type_e kind, input logic last);
        sym_data_i  = data;
        sym_type_i  = kind;
        sym_last_i  = last;
        sym_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        sym_valid_i = 1'b0;
    endtask

    task automatic read_register(input reg_addr_e addr, output reg_word_t word);
        int waited;
        waited      = 0;
        rd_addr_i   = addr;
        rd_strobe_i = 1'b1;
        @(posedge clk_i);
        #1;
        rd_strobe_i = 1'b0;
        while (!rd_valid_o && waited < 4) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (!rd_valid_o) begin
            error_count++;
            $display("%s: read of address %0d got no response", test_name, addr);
        end
        word = rd_data_o;
    endtask

    task automatic finish_test(input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, error_count - errors_before);
        end
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic reset_state_test();
        int        errs;
        reg_word_t w;
        errs      = error_count;
        test_name = "reset_state";
        read_register(REG_ID, w);
        check_word(`RX_CORE_ID, w);
        read_register(REG_LEVEL, w);
        check_level('0, fifo_level_t'(w));
        read_register(REG_STATUS, w);
        check_word(status_word_of(1'b0, 1'b1), w);
        read_register(REG_LLR_DATA, w);
        check_word('0, w);
        finish_test(errs);
    endtask

    task automatic pbch_selection_test();
        int          errs;
        reg_word_t   w;
        logic [31:0] r;
        iq_t         s;
        sym_type_e   kind;
        logic        last;
        reg_word_t   exp_words[$];
        errs      = error_count;
        test_name = "pbch_selection";
        for (int n = 0; n < 12; n++) begin
            r = lcg_next();
            s = iq_t'(r[31:16]);
            case (r[9:8])
                2'd1:    kind = SYM_DMRS;
                2'd2:    kind = SYM_OTHER;
                default: kind = SYM_PBCH;
            endcase
            last = r[12];
            if (kind == SYM_PBCH) begin
                exp_words.push_back(data_word_of(pair_from_symbol(s), last));
            end
            send_symbol(s, kind, last);
        end
        wait_cycles(3);
        read_register(REG_LEVEL, w);
        check_level(fifo_level_t'(exp_words.size()), fifo_level_t'(w));
        while (exp_words.size() > 0) begin
            read_register(REG_LLR_DATA, w);
            check_word(exp_words.pop_front(), w);
        end
        finish_test(errs);
    endtask

    task automatic saturation_test();
        int          errs;
        reg_word_t   w;
        logic [15:0] in_words[4];
        logic [15:0] exp_pairs[4];
        errs      = error_count;
        test_name = "saturation";
        in_words  = '{16'h8081, 16'h8180, 16'h007f, 16'h7f00};
        exp_pairs = '{16'h8181, 16'h8181, 16'h007f, 16'h7f00};
        for (int n = 0; n < 4; n++) begin
            send_symbol(iq_t'(in_words[n]), SYM_PBCH, n == 3);
        end
        wait_cycles(3);
        for (int n = 0; n < 4; n++) begin
            read_register(REG_LLR_DATA, w);
            check_pair(llr_pair_t'(exp_pairs[n]), llr_pair_t'(w[15:0]));
        end
        finish_test(errs);
    endtask

    task automatic overflow_test();
        int        errs;
        reg_word_t w;
        iq_t       s;
        reg_word_t exp_words[$];
        errs      = error_count;
        test_name = "overflow";
        for (int n = 0; n < 18; n++) begin
            s = iq_t'(lcg_next() >> 16);
            if (n < 16) begin
                exp_words.push_back(data_word_of(pair_from_symbol(s), n % 4 == 3));
            end
            send_symbol(s, SYM_PBCH, n % 4 == 3);
        end
        wait_cycles(3);
        read_register(REG_LEVEL, w);
        check_level(fifo_level_t'(16), fifo_level_t'(w));
        read_register(REG_STATUS, w);
        check_word(status_word_of(1'b1, 1'b0), w);
        while (exp_words.size() > 0) begin
            read_register(REG_LLR_DATA, w);
            check_word(exp_words.pop_front(), w);
        end
        read_register(REG_LLR_DATA, w);
        check_word('0, w);
        // overflow is sticky even once drained
        read_register(REG_STATUS, w);
        check_word(status_word_of(1'b1, 1'b1), w);
        finish_test(errs);
    endtask

    task automatic clear_test();
        int        errs;
        reg_word_t w;
        iq_t       s;
        reg_word_t exp_words[$];
        errs      = error_count;
        test_name = "clear";
        for (int n = 0; n < 18; n++) begin
            send_symbol(iq_t'(lcg_next() >> 16), SYM_PBCH, 1'b0);
        end
        wait_cycles(3);
        read_register(REG_STATUS, w);
        check_word(status_word_of(1'b1, 1'b0), w);
        for (int n = 0; n < 4; n++) begin
            read_register(REG_LLR_DATA, w);
        end
        // one pair leaves the demapper and another enters it as clear lands
        send_symbol(iq_t'(lcg_next() >> 16), SYM_PBCH, 1'b0);
        sym_data_i  = iq_t'(lcg_next() >> 16);
        sym_type_i  = SYM_PBCH;
        sym_last_i  = 1'b1;
        sym_valid_i = 1'b1;
        clear_i     = 1'b1;
        @(posedge clk_i);
        #1;
        sym_valid_i = 1'b0;
        clear_i     = 1'b0;
        wait_cycles(3);
        read_register(REG_LEVEL, w);
        check_level('0, fifo_level_t'(w));
        read_register(REG_STATUS, w);
        check_word(status_word_of(1'b0, 1'b1), w);
        for (int n = 0; n < 2; n++) begin
            s = iq_t'(lcg_next() >> 16);
            exp_words.push_back(data_word_of(pair_from_symbol(s), n == 1));
            send_symbol(s, SYM_PBCH, n == 1);
        end
        wait_cycles(3);
        read_register(REG_LEVEL, w);
        check_level(fifo_level_t'(2), fifo_level_t'(w));
        while (exp_words.size() > 0) begin
            read_register(REG_LLR_DATA, w);
            check_word(exp_words.pop_front(), w);
        end
        finish_test(errs);
    endtask

    task automatic back_to_back_test();
        int        errs;
        int        ready;
        int        popped;
        reg_word_t w;
        iq_t       s;
        logic      last;
        logic      strobed;
        reg_word_t exp_words[$];
        errs      = error_count;
        popped    = 0;
        test_name = "back_to_back";
        for (int c = 0; c < 24; c++) begin
            if (c < 16) begin
                s    = iq_t'(lcg_next() >> 16);
                last = (c % 5 == 4);
                exp_words.push_back(data_word_of(pair_from_symbol(s), last));
                sym_data_i  = s;
                sym_type_i  = SYM_PBCH;
                sym_last_i  = last;
                sym_valid_i = 1'b1;
            end else begin
                sym_valid_i = 1'b0;
            end
            // symbols sent at least 3 cycles before this strobe
            ready = (c >= 3) ? c - 2 : 0;
            if (ready > 16) begin
                ready = 16;
            end
            strobed     = (c % 2 == 0);
            rd_addr_i   = REG_LLR_DATA;
            rd_strobe_i = strobed;
            @(posedge clk_i);
            #1;
            if (strobed && !rd_valid_o) begin
                error_count++;
                $display("%s: data read in cycle %0d got no response", test_name, c);
            end else if (strobed && rd_data_o[DATA_VALID_BIT]) begin
                if (exp_words.size() == 0) begin
                    error_count++;
                    $display("%s: data read returned an entry never sent", test_name);
                end else begin
                    check_word(exp_words.pop_front(), rd_data_o);
                    popped++;
                end
            end else if (strobed && popped < ready) begin
                error_count++;
                $display("%s: data read in cycle %0d found no entry although one was due",
                         test_name, c);
            end
        end
        sym_valid_i = 1'b0;
        rd_strobe_i = 1'b0;
        wait_cycles(3);
        read_register(REG_LEVEL, w);
        check_level(fifo_level_t'(exp_words.size()), fifo_level_t'(w));
        while (exp_words.size() > 0) begin
            read_register(REG_LLR_DATA, w);
            check_word(exp_words.pop_front(), w);
        end
        finish_test(errs);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        lcg_state   = 32'h66f3_393f;
        check_count = 0;
        error_count = 0;
        test_count  = 0;
        reset_ni    = 1'b0;
        clear_i     = 1'b0;
        sym_data_i  = '0;
        sym_type_i  = SYM_OTHER;
        sym_last_i  = 1'b0;
        sym_valid_i = 1'b0;
        rd_addr_i   = REG_ID;
        rd_strobe_i = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;

        reset_state_test();
        pbch_selection_test();
        saturation_test();
        overflow_test();
        clear_test();
        back_to_back_test();

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
